//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = npc_tb
FILELIST  = npc.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass line is in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- npc.f
source/npc_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/alu.sv
source/lsu.sv
source/npc.sv
tb/npc_properties.sv
tb/npc_tb.sv

//--- source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  npc_pkg::word_t  src1,
    input  npc_pkg::word_t  src2,
    input  npc_pkg::alu_op_e alu_op,
    output npc_pkg::word_t  result
);

    // shift amount from low five bits
    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            npc_pkg::alu_add: begin
                result = src1 + src2;
            end
            npc_pkg::alu_sub: begin
                result = src1 - src2;
            end
            npc_pkg::alu_xor: begin
                result = src1 ^ src2;
            end
            npc_pkg::alu_or: begin
                result = src1 | src2;
            end
            npc_pkg::alu_and: begin
                result = src1 & src2;
            end
            npc_pkg::alu_sll: begin
                result = src1 << shamt;
            end
            npc_pkg::alu_srl: begin
                result = src1 >> shamt;
            end
            // arithmetic shift keeps the sign
            npc_pkg::alu_sra: begin
                result = $signed(src1) >>> shamt;
            end
            // compares give 0 or 1
            npc_pkg::alu_slt: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            npc_pkg::alu_sltu: begin
                result = {31'b0, src1 < src2};
            end
            npc_pkg::alu_eq: begin
                result = {31'b0, src1 == src2};
            end
            npc_pkg::alu_ne: begin
                result = {31'b0, src1 != src2};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
    input  npc_pkg::word_t inst,
    output npc_pkg::ctrl_t ctrl
);

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // immediates, all sign extended
    npc_pkg::word_t imm_i;
    npc_pkg::word_t imm_s;
    npc_pkg::word_t imm_b;
    npc_pkg::word_t imm_u;
    npc_pkg::word_t imm_j;

    // set when funct3/funct7 name a supported op
    logic known;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // defaults give a no-op: no register or memory write
        ctrl          = '0;
        ctrl.rd       = inst[11:7];
        ctrl.rs1      = inst[19:15];
        ctrl.rs2      = inst[24:20];
        ctrl.alu_op   = npc_pkg::alu_add;
        ctrl.wb_sel   = npc_pkg::wb_alu;
        ctrl.mem_size = npc_pkg::size_word;
        known         = 1'b1;

        case (opcode)
            npc_pkg::op_lui: begin
                ctrl.imm     = imm_u;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = npc_pkg::wb_imm;
            end
            npc_pkg::op_auipc: begin
                // pc + imm through the alu
                ctrl.imm         = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen     = 1'b1;
            end
            npc_pkg::op_jal: begin
                ctrl.imm     = imm_j;
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = npc_pkg::wb_pc_plus_4;
            end
            npc_pkg::op_jalr: begin
                // alu forms rs1 + imm as target
                known            = (funct3 == 3'b000);
                ctrl.imm         = imm_i;
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_jalr     = known;
                ctrl.reg_wen     = known;
                ctrl.wb_sel      = npc_pkg::wb_pc_plus_4;
            end
            npc_pkg::op_branch: begin
                ctrl.imm = imm_b;
                case (funct3)
                    3'b000: ctrl.alu_op = npc_pkg::alu_eq;
                    3'b001: ctrl.alu_op = npc_pkg::alu_ne;
                    // bge is not slt
                    3'b101: begin
                        ctrl.alu_op         = npc_pkg::alu_slt;
                        ctrl.branch_on_zero = 1'b1;
                    end
                    3'b110: ctrl.alu_op = npc_pkg::alu_sltu;
                    // bgeu is not sltu
                    3'b111: begin
                        ctrl.alu_op         = npc_pkg::alu_sltu;
                        ctrl.branch_on_zero = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
                ctrl.is_branch = known;
            end
            npc_pkg::op_load: begin
                ctrl.imm         = imm_i;
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_sel      = npc_pkg::wb_mem;
                case (funct3)
                    3'b010:  ctrl.mem_size = npc_pkg::size_word;
                    3'b100:  ctrl.mem_size = npc_pkg::size_byte;
                    default: known = 1'b0;
                endcase
                ctrl.is_load = known;
                ctrl.reg_wen = known;
            end
            npc_pkg::op_store: begin
                ctrl.imm         = imm_s;
                ctrl.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_size = npc_pkg::size_byte;
                    3'b001:  ctrl.mem_size = npc_pkg::size_half;
                    3'b010:  ctrl.mem_size = npc_pkg::size_word;
                    default: known = 1'b0;
                endcase
                ctrl.is_store = known;
            end
            npc_pkg::op_imm: begin
                ctrl.imm         = imm_i;
                ctrl.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = npc_pkg::alu_add;
                    3'b100: ctrl.alu_op = npc_pkg::alu_xor;
                    3'b111: ctrl.alu_op = npc_pkg::alu_and;
                    3'b011: ctrl.alu_op = npc_pkg::alu_sltu;
                    3'b001: begin
                        ctrl.alu_op = npc_pkg::alu_sll;
                        known       = (funct7 == 7'b0000000);
                    end
                    // funct7 picks logical or arithmetic shift
                    3'b101: begin
                        ctrl.alu_op = funct7[5] ? npc_pkg::alu_sra : npc_pkg::alu_srl;
                        known       = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    default: known = 1'b0;
                endcase
                ctrl.reg_wen = known;
            end
            npc_pkg::op_reg: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  ctrl.alu_op = npc_pkg::alu_add;
                        3'b001:  ctrl.alu_op = npc_pkg::alu_sll;
                        3'b010:  ctrl.alu_op = npc_pkg::alu_slt;
                        3'b011:  ctrl.alu_op = npc_pkg::alu_sltu;
                        3'b100:  ctrl.alu_op = npc_pkg::alu_xor;
                        3'b101:  ctrl.alu_op = npc_pkg::alu_srl;
                        3'b110:  ctrl.alu_op = npc_pkg::alu_or;
                        default: ctrl.alu_op = npc_pkg::alu_and;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = npc_pkg::alu_sub;
                end else begin
                    known = 1'b0;
                end
                ctrl.reg_wen = known;
            end
            default: begin
                // only ebreak among system ops
                ctrl.is_ebreak = (inst == npc_pkg::ebreak_inst);
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
    input  npc_pkg::ctrl_t     ctrl,
    input  npc_pkg::word_t     addr,
    input  npc_pkg::word_t     store_data,
    input  npc_pkg::word_t     mem_rdata,
    input  wire                enable,
    output npc_pkg::dmem_req_t dmem_req,
    output logic               dmem_ren,
    output npc_pkg::word_t     load_data
);

    // addressed byte of the read word
    npc_pkg::word_t shifted_rdata;

    assign shifted_rdata = mem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        dmem_req.addr = addr;
        // data copied into every lane, mask picks the ones written
        case (ctrl.mem_size)
            npc_pkg::size_byte: begin
                dmem_req.wdata = {4{store_data[7:0]}};
                dmem_req.wmask = 4'b0001 << addr[1:0];
            end
            npc_pkg::size_half: begin
                dmem_req.wdata = {2{store_data[15:0]}};
                dmem_req.wmask = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_req.wdata = store_data;
                dmem_req.wmask = 4'b1111;
            end
        endcase
        // no access during reset or halt
        dmem_req.wen = enable & ctrl.is_store;
        dmem_ren     = enable & ctrl.is_load;
    end

    // lbu zero extends, lw passes the word
    always_comb begin
        if (ctrl.mem_size == npc_pkg::size_byte) begin
            load_data = {24'b0, shifted_rdata[7:0]};
        end else begin
            load_data = mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/npc.sv
`timescale 1ns/10ps
`default_nettype none

module npc (
    input  wire                clk,
    input  wire                reset,
    input  npc_pkg::word_t     imem_data,
    output npc_pkg::word_t     imem_addr,
    input  npc_pkg::word_t     dmem_rdata,
    output npc_pkg::dmem_req_t dmem_req,
    output logic               dmem_ren,
    output logic               halt
);

    npc_pkg::word_t pc;
    npc_pkg::word_t next_pc;
    npc_pkg::word_t pc_plus_4;
    npc_pkg::word_t pc_plus_imm;
    npc_pkg::ctrl_t ctrl;

    // register file and alu data
    npc_pkg::word_t rs1_data;
    npc_pkg::word_t rs2_data;
    npc_pkg::word_t alu_src1;
    npc_pkg::word_t alu_src2;
    npc_pkg::word_t alu_result;
    npc_pkg::word_t load_data;
    npc_pkg::word_t wb_data;

    logic branch_taken;
    logic reg_wen;
    logic enable;

    assign imem_addr = pc;

    // ebreak holds the core until reset
    assign halt   = ctrl.is_ebreak & ~reset;
    assign enable = ~reset & ~halt;

    inst_decode u_decode (
        .inst (imem_data),
        .ctrl (ctrl)
    );

    assign reg_wen = ctrl.reg_wen & ~halt;

    reg_file u_regfile (
        .clk    (clk),
        .reset  (reset),
        .wen    (reg_wen),
        .waddr  (ctrl.rd),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .wdata  (wb_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // pc only for auipc, imm for immediate forms
    assign alu_src1 = ctrl.src1_is_pc ? pc : rs1_data;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .src1   (alu_src1),
        .src2   (alu_src2),
        .alu_op (ctrl.alu_op),
        .result (alu_result)
    );

    lsu u_lsu (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .store_data (rs2_data),
        .mem_rdata  (dmem_rdata),
        .enable     (enable),
        .dmem_req   (dmem_req),
        .dmem_ren   (dmem_ren),
        .load_data  (load_data)
    );

    // writeback mux
    always_comb begin
        case (ctrl.wb_sel)
            npc_pkg::wb_mem:       wb_data = load_data;
            npc_pkg::wb_pc_plus_4: wb_data = pc_plus_4;
            npc_pkg::wb_imm:       wb_data = ctrl.imm;
            default:               wb_data = alu_result;
        endcase
    end

    // bge and bgeu invert the compare
    assign branch_taken = ctrl.is_branch &
                          ((alu_result != '0) ^ ctrl.branch_on_zero);

    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_imm = pc + ctrl.imm;

    // jalr target with bit 0 cleared
    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = alu_result & ~32'd1;
        end else if (ctrl.is_jal || branch_taken) begin
            next_pc = pc_plus_imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= npc_pkg::reset_pc;
        end else if (!halt) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- source/npc_pkg.sv
`default_nettype none

package npc_pkg;

    // basic word and index types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // pc after reset
    localparam word_t reset_pc = 32'h8000_0000;

    // ebreak, full encoding
    localparam word_t ebreak_inst = 32'h0010_0073;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu functions
    // eq and ne only used by branches
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_sltu, alu_eq, alu_ne
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_pc_plus_4, wb_imm
    } wb_sel_e;

    // access width for loads and stores
    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_e;

    // decoded control for one instruction
    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      reg_wen;
        wb_sel_e   wb_sel;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        logic      is_branch;
        // bge and bgeu take the branch on a zero compare
        logic      branch_on_zero;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
    } ctrl_t;

    // one data memory access
    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] wmask;
        logic       wen;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                clk,
    input  wire                reset,
    input  wire                wen,
    input  npc_pkg::reg_addr_t waddr,
    input  npc_pkg::reg_addr_t raddr1,
    input  npc_pkg::reg_addr_t raddr2,
    input  npc_pkg::word_t     wdata,
    output npc_pkg::word_t     rdata1,
    output npc_pkg::word_t     rdata2
);

    // x0 entry kept but never written
    npc_pkg::word_t regs [32];

    // write at the retire edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 reads as zero
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

//--- tb/npc_properties.sv
`timescale 1ns/10ps
`default_nettype none

module npc_properties (
    input wire                clk,
    input wire                reset,
    input npc_pkg::word_t     imem_addr,
    input npc_pkg::dmem_req_t dmem_req,
    input wire                dmem_ren,
    input wire                halt
);

    // one access per instruction, never both
    a_no_read_with_write: assert property (@(posedge clk)
        !(dmem_req.wen && dmem_ren))
        else $error("dmem write and read strobes high together");

    a_no_write_in_reset: assert property (@(posedge clk)
        reset |-> !dmem_req.wen)
        else $error("dmem write strobe high during reset");

    // ebreak freezes the pc
    a_pc_held_on_halt: assert property (@(posedge clk) disable iff (reset)
        halt |=> imem_addr == $past(imem_addr))
        else $error("pc moved while halted");

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        imem_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind npc npc_properties u_props (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req),
    .dmem_ren  (dmem_ren),
    .halt      (halt)
);

`default_nettype wire

//--- tb/npc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module npc_tb;

    // 8 KB of word memory, address bits 12:2 pick the word
    localparam int mem_words = 2048;
    localparam npc_pkg::word_t data_base = 32'h8000_1000;

    logic                clk;
    logic                reset;
    npc_pkg::word_t      imem_addr;
    npc_pkg::word_t      imem_data;
    npc_pkg::word_t      dmem_rdata;
    npc_pkg::dmem_req_t  dmem_req;
    logic                dmem_ren;
    logic                halt;

    npc_pkg::word_t      mem [mem_words];
    npc_pkg::word_t      prog_q [$];
    npc_pkg::dmem_req_t  exp_q [$];
    npc_pkg::word_t      load_q [$];
    logic [11:0]         off;
    int                  cycles;
    int                  cycle_limit;
    int                  store_idx;
    int                  load_idx;
    npc_pkg::word_t      halt_pc;

    npc u_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .dmem_ren   (dmem_ren),
        .halt       (halt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // both memory reads are combinational
    assign imem_data  = mem[imem_addr[12:2]];
    assign dmem_rdata = mem[dmem_req.addr[12:2]];

    // masked byte writes at the retire edge
    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    mem[dmem_req.addr[12:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // small rv32i encoders
    function automatic npc_pkg::word_t r_format(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic npc_pkg::word_t i_format(input logic [6:0] op, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic npc_pkg::word_t s_format(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic npc_pkg::word_t b_format(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic npc_pkg::word_t u_format(input logic [6:0] op, input logic [4:0] rd,
                                                input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic npc_pkg::word_t j_format(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // address of the next instruction placed
    function automatic npc_pkg::word_t next_pc();
        return npc_pkg::reset_pc + 32'(4 * prog_q.size());
    endfunction

    task automatic add_inst(input npc_pkg::word_t inst);
        prog_q.push_back(inst);
    endtask

    task automatic expect_store(input npc_pkg::word_t addr, input npc_pkg::word_t data,
                                input logic [3:0] mask);
        npc_pkg::dmem_req_t req;
        req.addr  = addr;
        req.wdata = data;
        req.wmask = mask;
        req.wen   = 1'b1;
        exp_q.push_back(req);
    endtask

    // result lands in x5, then sw x5 to the next slot
    task automatic op_and_store(input npc_pkg::word_t inst, input npc_pkg::word_t result);
        add_inst(inst);
        add_inst(s_format(3'b010, 5'd10, 5'd5, off));
        expect_store(data_base + 32'(off), result, 4'b1111);
        off = off + 12'd4;
    endtask

    // first branch taken skips its store, second falls through to it
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ta, input logic [4:0] tb,
                               input logic [4:0] na, input logic [4:0] nb);
        add_inst(b_format(f3, ta, tb, 13'd8));
        add_inst(s_format(3'b010, 5'd10, 5'd3, off));
        off = off + 12'd4;
        add_inst(b_format(f3, na, nb, 13'd8));
        add_inst(s_format(3'b010, 5'd10, 5'd3, off));
        expect_store(data_base + 32'(off), 32'd5, 4'b1111);
        off = off + 12'd4;
    endtask

    task automatic build_program();
        npc_pkg::word_t link_pc;
        off = 12'h000;
        // sw x0 at reset_pc, held off while reset is high
        add_inst(s_format(3'b010, 5'd0, 5'd0, 12'h800));
        expect_store(32'hFFFF_F800, 32'h0000_0000, 4'b1111);
        // x10 data base, x1 = 0x12345678, x2 = -3, x3 = 5
        add_inst(u_format(7'b0110111, 5'd10, 20'h80001));
        add_inst(u_format(7'b0110111, 5'd1, 20'h12345));
        add_inst(i_format(7'b0010011, 3'b000, 5'd1, 5'd1, 12'h678));
        add_inst(i_format(7'b0010011, 3'b000, 5'd2, 5'd0, 12'hFFD));
        add_inst(i_format(7'b0010011, 3'b000, 5'd3, 5'd0, 12'h005));
        // register ops
        op_and_store(r_format(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), 32'h1234_5675);
        op_and_store(r_format(7'h20, 3'b000, 5'd5, 5'd1, 5'd3), 32'h1234_5673);
        op_and_store(r_format(7'h00, 3'b100, 5'd5, 5'd1, 5'd2), 32'hEDCB_A985);
        op_and_store(r_format(7'h00, 3'b110, 5'd5, 5'd1, 5'd3), 32'h1234_567D);
        op_and_store(r_format(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), 32'h1234_5678);
        op_and_store(r_format(7'h00, 3'b001, 5'd5, 5'd1, 5'd3), 32'h468A_CF00);
        op_and_store(r_format(7'h00, 3'b101, 5'd5, 5'd2, 5'd3), 32'h07FF_FFFF);
        op_and_store(r_format(7'h00, 3'b010, 5'd5, 5'd2, 5'd3), 32'h0000_0001);
        op_and_store(r_format(7'h00, 3'b011, 5'd5, 5'd2, 5'd3), 32'h0000_0000);
        // immediate ops
        op_and_store(i_format(7'b0010011, 3'b000, 5'd5, 5'd1, 12'h988), 32'h1234_5000);
        op_and_store(i_format(7'b0010011, 3'b100, 5'd5, 5'd1, 12'h0FF), 32'h1234_5687);
        op_and_store(i_format(7'b0010011, 3'b111, 5'd5, 5'd1, 12'h0F0), 32'h0000_0070);
        op_and_store(i_format(7'b0010011, 3'b011, 5'd5, 5'd3, 12'h006), 32'h0000_0001);
        op_and_store(i_format(7'b0010011, 3'b001, 5'd5, 5'd3, 12'h004), 32'h0000_0050);
        op_and_store(i_format(7'b0010011, 3'b101, 5'd5, 5'd2, 12'h01C), 32'h0000_000F);
        op_and_store(i_format(7'b0010011, 3'b101, 5'd5, 5'd2, 12'h401), 32'hFFFF_FFFE);
        // beq, bne, bge, bltu, bgeu
        branch_pair(3'b000, 5'd3, 5'd3, 5'd3, 5'd2);
        branch_pair(3'b001, 5'd3, 5'd2, 5'd3, 5'd3);
        branch_pair(3'b101, 5'd3, 5'd2, 5'd2, 5'd3);
        branch_pair(3'b110, 5'd3, 5'd2, 5'd2, 5'd3);
        branch_pair(3'b111, 5'd2, 5'd3, 5'd3, 5'd2);
        // jal over one store, then store the link
        link_pc = next_pc() + 32'd4;
        add_inst(j_format(5'd7, 21'd8));
        add_inst(s_format(3'b010, 5'd10, 5'd3, off));
        off = off + 12'd4;
        add_inst(s_format(3'b010, 5'd10, 5'd7, off));
        expect_store(data_base + 32'(off), link_pc, 4'b1111);
        off = off + 12'd4;
        // auipc x8, jalr x9 to auipc + 16
        link_pc = next_pc();
        add_inst(u_format(7'b0010111, 5'd8, 20'h00000));
        add_inst(i_format(7'b1100111, 3'b000, 5'd9, 5'd8, 12'd16));
        add_inst(s_format(3'b010, 5'd10, 5'd3, off));
        off = off + 12'd4;
        add_inst(s_format(3'b010, 5'd10, 5'd3, off));
        off = off + 12'd4;
        add_inst(s_format(3'b010, 5'd10, 5'd9, off));
        expect_store(data_base + 32'(off), link_pc + 32'd8, 4'b1111);
        off = off + 12'd4;
        add_inst(s_format(3'b010, 5'd10, 5'd8, off));
        expect_store(data_base + 32'(off), link_pc, 4'b1111);
        off = off + 12'd4;
        // x11 = 0xA1B2C3D4, sb at every byte, sh at both halves
        add_inst(u_format(7'b0110111, 5'd11, 20'hA1B2C));
        add_inst(i_format(7'b0010011, 3'b000, 5'd11, 5'd11, 12'h3D4));
        for (int b = 0; b < 4; b++) begin
            add_inst(s_format(3'b000, 5'd10, 5'd11, off + 12'(b)));
            expect_store(data_base + 32'(off) + 32'(b), 32'h0000_00D4 << (8 * b),
                         4'b0001 << b);
        end
        off = off + 12'd4;
        add_inst(s_format(3'b001, 5'd10, 5'd11, off));
        expect_store(data_base + 32'(off), 32'h0000_C3D4, 4'b0011);
        add_inst(s_format(3'b001, 5'd10, 5'd11, off + 12'd2));
        expect_store(data_base + 32'(off) + 32'd2, 32'hC3D4_0000, 4'b1100);
        off = off + 12'd4;
        // lbu of the top byte, then lw of the whole preset word
        load_q.push_back(data_base + 32'h0000_0103);
        op_and_store(i_format(7'b0000011, 3'b100, 5'd5, 5'd10, 12'h103), 32'h0000_0087);
        load_q.push_back(data_base + 32'h0000_0100);
        op_and_store(i_format(7'b0000011, 3'b010, 5'd5, 5'd10, 12'h100), 32'h8765_43A9);
        halt_pc = next_pc();
        add_inst(32'h0010_0073);
    endtask

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input npc_pkg::word_t actual, input npc_pkg::word_t expected,
                              input string name);
        if (actual !== expected) begin
            $display("** Error: %s actual=%h expected=%h", name, actual, expected);
            abort_run();
        end
    endtask

    // wdata is compared only in the written lanes
    task automatic check_store(input npc_pkg::dmem_req_t actual,
                               input npc_pkg::dmem_req_t expected);
        npc_pkg::word_t lanes;
        lanes = {{8{expected.wmask[3]}}, {8{expected.wmask[2]}},
                 {8{expected.wmask[1]}}, {8{expected.wmask[0]}}};
        if (actual.addr !== expected.addr || actual.wmask !== expected.wmask ||
            actual.wen !== expected.wen ||
            (actual.wdata & lanes) !== (expected.wdata & lanes)) begin
            $display("** Error: dmem_req actual=%h expected=%h", actual, expected);
            abort_run();
        end
    endtask

    initial begin
        void'($urandom(19927));
        reset = 1'b1;
        store_idx = 0;
        load_idx = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = $urandom;
        end
        // preset word for lbu and lw
        mem[(data_base[12:2]) + 11'h040] = 32'h8765_43A9;
        build_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            mem[npc_pkg::reset_pc[12:2] + 11'(i)] = prog_q[i];
        end
        cycle_limit = 2 * prog_q.size() + 20;

        // reset holds pc and blocks writes
        repeat (5) begin
            @(posedge clk);
            #1;
            check_word(imem_addr, npc_pkg::reset_pc, "imem_addr");
            if (dmem_req.wen) begin
                $display("write strobe seen during reset");
                abort_run();
            end
        end
        reset = 1'b0;

        // sample each instruction mid cycle, before it retires
        cycles = 0;
        @(negedge clk);
        while (!halt && cycles < cycle_limit) begin
            if (dmem_req.wen) begin
                if (store_idx >= exp_q.size()) begin
                    $display("more stores than the table lists");
                    abort_run();
                end
                check_store(dmem_req, exp_q[store_idx]);
                store_idx++;
            end
            if (dmem_ren) begin
                if (load_idx >= load_q.size()) begin
                    $display("more loads than the program holds");
                    abort_run();
                end
                check_word(dmem_req.addr, load_q[load_idx], "dmem_req.addr");
                load_idx++;
            end
            cycles++;
            @(negedge clk);
        end
        if (!halt) begin
            $display("halt not reached within %0d cycles", cycle_limit);
            abort_run();
        end

        // pc must sit on the ebreak
        check_word(imem_addr, halt_pc, "imem_addr");
        repeat (3) @(negedge clk);
        check_word(imem_addr, halt_pc, "imem_addr");
        if (!halt) begin
            $display("halt dropped after ebreak");
            abort_run();
        end

        if (load_idx != load_q.size()) begin
            $display("halt reached after %0d of %0d loads", load_idx, load_q.size());
            abort_run();
        end

        if (store_idx != exp_q.size()) begin
            $display("halt reached after %0d of %0d stores", store_idx, exp_q.size());
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
